// File: rtl/esaxi_pkg.sv
package esaxi_pkg;

   // ################################################
   // widths
   // ################################################

   localparam int id_w   = 12;   // axi id
   localparam int addr_w = 32;   // mesh address
   localparam int data_w = 32;   // mesh data

   // axi size codes, anything above half is a full word
   localparam logic [2:0] size_byte = 3'd0;
   localparam logic [2:0] size_half = 3'd1;

   localparam logic [1:0] burst_incr  = 2'b01;   // fixed and wrap hold the address
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   localparam logic [data_w-1:0] timeout_data = 32'hdeadbeef;   // marker on expiry

   // ################################################
   // mesh packet, 104 bits, write at bit 0
   // ################################################

   typedef struct packed {
      logic [addr_w-1:0] srcaddr;    // return address for reads
      logic [data_w-1:0] data;
      logic [addr_w-1:0] dstaddr;
      logic [4:0]        ctrlmode;
      logic [1:0]        datamode;   // 0 byte .. 2 word
      logic              write;
   } emesh_packet_t;

   // ################################################
   // axi channel payloads
   // ################################################

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_aw_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [3:0]        strb;
      logic              last;
   } axi_w_t;

   typedef struct packed {
      logic [id_w-1:0] id;
      logic [1:0]      resp;
   } axi_b_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [7:0]        len;    // beats minus one
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_ar_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

endpackage

// File: rtl/axi_write_slave.sv
`timescale 1ns/1ps

module axi_write_slave
  (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   input  esaxi_pkg::axi_aw_t            s_axi_aw,
   input  logic                          s_axi_awvalid,
   output logic                          s_axi_awready,
   input  logic                          s_axi_wvalid,
   input  logic                          s_axi_wlast_in,
   output logic                          s_axi_wready,
   output esaxi_pkg::axi_b_t             s_axi_b,
   output logic                          s_axi_bvalid,
   input  logic                          s_axi_bready,
   input  logic                          wr_wait,
   output logic                          beat_take,
   output logic [esaxi_pkg::addr_w-1:0]  beat_addr,
   output logic [2:0]                    beat_size
  );

   import esaxi_pkg::*;

   logic              write_active;   // address taken until the last beat
   logic              aw_take;
   logic              last_beat;
   logic [id_w-1:0]   aw_id;          // echoed on b
   logic [addr_w-1:0] aw_addr;        // current word address
   logic [2:0]        aw_size;
   logic [1:0]        aw_burst;

   assign aw_take   = s_axi_awready & s_axi_awvalid;
   assign beat_take = s_axi_wready & s_axi_wvalid;
   assign last_beat = beat_take & s_axi_wlast_in;

   // ################################################
   // address channel and write state
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b1;
         write_active  <= 1'b0;
      end
      else
      begin
         // reopen only once the write and its response are both done
         if (!s_axi_awready && !write_active && !s_axi_bvalid)
            s_axi_awready <= 1'b1;
         else if (aw_take)
            s_axi_awready <= 1'b0;
         if (aw_take)
            write_active <= 1'b1;
         else if (last_beat)
            write_active <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_take)
      begin
         aw_id    <= s_axi_aw.id;
         aw_addr  <= s_axi_aw.addr;
         aw_size  <= s_axi_aw.size;
         aw_burst <= s_axi_aw.burst;
      end
      else if (beat_take && aw_burst == burst_incr)
         aw_addr <= {aw_addr[addr_w-1:2] + 1'b1, 2'b00};   // next word
   end

   assign beat_addr = aw_addr;
   assign beat_size = aw_size;

   // ################################################
   // data ready and response
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_wready <= 1'b0;
         s_axi_bvalid <= 1'b0;
      end
      else
      begin
         if (last_beat)
            s_axi_wready <= 1'b0;
         else
            s_axi_wready <= write_active & ~wr_wait;   // throttle from mesh
         if (last_beat)
            s_axi_bvalid <= 1'b1;
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;   // held until taken
      end
   end

   assign s_axi_b.id   = aw_id;
   assign s_axi_b.resp = resp_okay;   // writes never fail

   // data ready only between address and response
   a_wready_active : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_wready |-> !s_axi_awready && !s_axi_bvalid);

endmodule

// File: rtl/write_packer.sv
`timescale 1ns/1ps

module write_packer
  (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   input  logic                          beat_take,
   input  logic [esaxi_pkg::addr_w-1:0]  beat_addr,
   input  logic [2:0]                    beat_size,
   input  esaxi_pkg::axi_w_t             s_axi_w,
   output logic                          wr_access,
   output esaxi_pkg::emesh_packet_t      wr_packet
  );

   import esaxi_pkg::*;

   logic [1:0]        lo_idx;     // lowest set strobe
   logic              s1_valid;
   logic [addr_w-1:0] s1_addr;
   logic [data_w-1:0] s1_data;    // aligned to byte 0
   logic [1:0]        s1_mode;

   always_comb
   begin
      if (s_axi_w.strb[0])
         lo_idx = 2'd0;
      else if (s_axi_w.strb[1])
         lo_idx = 2'd1;
      else if (s_axi_w.strb[2])
         lo_idx = 2'd2;
      else
         lo_idx = 2'd3;   // strb[3], or no strobe at all
   end

   // ################################################
   // stage one, byte alignment
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s1_valid  <= 1'b0;
         wr_access <= 1'b0;
      end
      else
      begin
         s1_valid  <= beat_take;
         wr_access <= s1_valid;   // lines up with the packet below
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (beat_take)
      begin
         s1_addr <= {beat_addr[addr_w-1:2], lo_idx};
         s1_data <= s_axi_w.data >> {lo_idx, 3'b000};
         s1_mode <= beat_size[1:0];
      end
   end

   // stage two, packet register
   always_ff @(posedge s_axi_aclk)
   begin
      if (s1_valid)
      begin
         wr_packet.write    <= 1'b1;
         wr_packet.datamode <= s1_mode;
         wr_packet.ctrlmode <= 5'd0;
         wr_packet.dstaddr  <= s1_addr;
         wr_packet.data     <= s1_data;
         wr_packet.srcaddr  <= '0;   // no return for writes
      end
   end

endmodule

// File: rtl/axi_read_slave.sv
`timescale 1ns/1ps

module axi_read_slave
  #(
   parameter logic [esaxi_pkg::addr_w-1:0] return_addr = '0
  )
  (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   input  esaxi_pkg::axi_ar_t            s_axi_ar,
   input  logic                          s_axi_arvalid,
   output logic                          s_axi_arready,
   input  logic                          r_take,
   input  logic                          rd_wait,
   output logic                          rd_access,
   output esaxi_pkg::emesh_packet_t      rd_packet,
   output logic                          req_issued,
   output logic [2:0]                    cur_size,
   output logic [esaxi_pkg::id_w-1:0]    rid,
   output logic                          rlast
  );

   import esaxi_pkg::*;

   logic              ar_take;
   logic              read_active;   // one burst at a time
   logic              ractive_q;     // edge detect for the first request
   logic              rnext;         // non-last beat went out
   logic [addr_w-1:0] ar_addr;
   logic [7:0]        ar_len;        // beats left minus one
   logic [1:0]        ar_burst;

   assign ar_take    = s_axi_arready & s_axi_arvalid;
   assign req_issued = rd_access & ~rd_wait;

   // ################################################
   // address channel and beat count
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b0;
         read_active   <= 1'b0;
         ar_len        <= 8'd0;
         rlast         <= 1'b0;
      end
      else
      begin
         if (!s_axi_arready && !read_active)
            s_axi_arready <= 1'b1;
         else if (ar_take)
            s_axi_arready <= 1'b0;
         if (ar_take)
            read_active <= 1'b1;
         else if (r_take && rlast)
            read_active <= 1'b0;   // burst done
         if (ar_take)
         begin
            ar_len <= s_axi_ar.len;
            rlast  <= (s_axi_ar.len == 8'd0);
         end
         else if (r_take)
         begin
            ar_len <= ar_len - 1'b1;
            if (ar_len == 8'd1)
               rlast <= 1'b1;   // one beat remains
         end
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_take)
      begin
         ar_addr  <= s_axi_ar.addr;
         ar_burst <= s_axi_ar.burst;
         cur_size <= s_axi_ar.size;
         rid      <= s_axi_ar.id;
      end
      else if (r_take && ar_burst == burst_incr)
         ar_addr <= {ar_addr[addr_w-1:2] + 1'b1, 2'b00};
   end

   // ################################################
   // read request to mesh
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q <= 1'b0;
         rnext     <= 1'b0;
         rd_access <= 1'b0;
      end
      else
      begin
         ractive_q <= read_active;
         rnext     <= r_take & ~rlast;
         if (!(rd_access && rd_wait))   // hold while mesh stalls
            rd_access <= (read_active & ~ractive_q) | rnext;
      end
   end

   assign rd_packet.write    = 1'b0;
   assign rd_packet.datamode = cur_size[1:0];
   assign rd_packet.ctrlmode = 5'd0;
   assign rd_packet.dstaddr  = ar_addr;   // stable until the beat returns
   assign rd_packet.data     = '0;
   assign rd_packet.srcaddr  = return_addr;

   // a request only starts inside a read burst
   a_req_in_burst : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      $rose(rd_access) |-> read_active);

endmodule

// File: rtl/read_return.sv
`timescale 1ns/1ps

module read_return
  #(
   parameter int tw = 16   // timeout counter width
  )
  (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   input  logic                          rr_access,
   input  esaxi_pkg::emesh_packet_t      rr_packet,
   input  logic                          req_issued,
   input  logic [2:0]                    cur_size,
   input  logic [esaxi_pkg::id_w-1:0]    rid,
   input  logic                          rlast,
   output esaxi_pkg::axi_r_t             s_axi_r,
   output logic                          s_axi_rvalid,
   input  logic                          s_axi_rready,
   output logic                          r_take
  );

   import esaxi_pkg::*;

   localparam logic [1:0] st_idle    = 2'd0;
   localparam logic [1:0] st_armed   = 2'd1;
   localparam logic [1:0] st_expired = 2'd2;

   logic [1:0]        to_state;
   logic [tw-1:0]     to_count;
   logic              to_access;    // expiry strobe
   logic              ret_access;   // response or expiry
   logic [data_w-1:0] ret_data;
   logic [data_w-1:0] r_data;
   logic [1:0]        r_resp;

   assign r_take     = s_axi_rvalid & s_axi_rready;
   assign to_access  = (to_state == st_expired);
   assign ret_access = rr_access | to_access;
   assign ret_data   = to_access ? timeout_data : rr_packet.data;

   // ################################################
   // timeout
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         to_state <= st_idle;
      else
         case (to_state)
            st_idle    : if (req_issued) to_state <= st_armed;
            st_armed   : if (rr_access)
                            to_state <= st_idle;   // response wins a tie
                         else if (to_count == '0)
                            to_state <= st_expired;
            default    : to_state <= st_idle;     // expired lasts one cycle
         endcase
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (to_state == st_idle)
         to_count <= '1;   // full count for each request
      else if (to_state == st_armed)
         to_count <= to_count - 1'b1;
   end

   // ################################################
   // r channel
   // ################################################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (ret_access)
         s_axi_rvalid <= 1'b1;
      else if (r_take)
         s_axi_rvalid <= 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (ret_access)
      begin
         r_resp <= to_access ? resp_slverr : resp_okay;
         case (cur_size)
            size_byte : r_data <= {4{ret_data[7:0]}};    // byte on every lane
            size_half : r_data <= {2{ret_data[15:0]}};
            default   : r_data <= ret_data;
         endcase
      end
   end

   assign s_axi_r.id   = rid;
   assign s_axi_r.data = r_data;
   assign s_axi_r.resp = r_resp;
   assign s_axi_r.last = rlast;

   // responses only for an outstanding request
   a_rr_armed : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      rr_access |-> to_state != st_idle);

endmodule

// File: rtl/esaxi_top.sv
`timescale 1ns/1ps

module esaxi_top
  #(
   parameter int                           tw          = 16,
   parameter logic [esaxi_pkg::addr_w-1:0] return_addr = '0
  )
  (
   input  logic                      s_axi_aclk,
   input  logic                      s_axi_aresetn,
   // write channels
   input  esaxi_pkg::axi_aw_t        s_axi_aw,
   input  logic                      s_axi_awvalid,
   output logic                      s_axi_awready,
   input  esaxi_pkg::axi_w_t         s_axi_w,
   input  logic                      s_axi_wvalid,
   output logic                      s_axi_wready,
   output esaxi_pkg::axi_b_t         s_axi_b,
   output logic                      s_axi_bvalid,
   input  logic                      s_axi_bready,
   // read channels
   input  esaxi_pkg::axi_ar_t        s_axi_ar,
   input  logic                      s_axi_arvalid,
   output logic                      s_axi_arready,
   output esaxi_pkg::axi_r_t         s_axi_r,
   output logic                      s_axi_rvalid,
   input  logic                      s_axi_rready,
   // mesh side
   output logic                      wr_access,
   output esaxi_pkg::emesh_packet_t  wr_packet,
   input  logic                      wr_wait,
   output logic                      rd_access,
   output esaxi_pkg::emesh_packet_t  rd_packet,
   input  logic                      rd_wait,
   input  logic                      rr_access,
   input  esaxi_pkg::emesh_packet_t  rr_packet
  );

   import esaxi_pkg::*;

   logic              beat_take;    // accepted w beat
   logic [addr_w-1:0] beat_addr;
   logic [2:0]        beat_size;
   logic              req_issued;   // read request taken by mesh
   logic [2:0]        cur_size;
   logic [id_w-1:0]   rid;
   logic              rlast;
   logic              r_take;       // r handshake

   // ################################################
   // write path
   // ################################################

   axi_write_slave u_write_slave
     (
      .s_axi_aclk     (s_axi_aclk),
      .s_axi_aresetn  (s_axi_aresetn),
      .s_axi_aw       (s_axi_aw),
      .s_axi_awvalid  (s_axi_awvalid),
      .s_axi_awready  (s_axi_awready),
      .s_axi_wvalid   (s_axi_wvalid),
      .s_axi_wlast_in (s_axi_w.last),
      .s_axi_wready   (s_axi_wready),
      .s_axi_b        (s_axi_b),
      .s_axi_bvalid   (s_axi_bvalid),
      .s_axi_bready   (s_axi_bready),
      .wr_wait        (wr_wait),
      .beat_take      (beat_take),
      .beat_addr      (beat_addr),
      .beat_size      (beat_size)
     );

   write_packer u_write_packer
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .beat_take     (beat_take),
      .beat_addr     (beat_addr),
      .beat_size     (beat_size),
      .s_axi_w       (s_axi_w),
      .wr_access     (wr_access),
      .wr_packet     (wr_packet)
     );

   // ################################################
   // read path
   // ################################################

   axi_read_slave #(.return_addr(return_addr)) u_read_slave
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_ar      (s_axi_ar),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .r_take        (r_take),
      .rd_wait       (rd_wait),
      .rd_access     (rd_access),
      .rd_packet     (rd_packet),
      .req_issued    (req_issued),
      .cur_size      (cur_size),
      .rid           (rid),
      .rlast         (rlast)
     );

   read_return #(.tw(tw)) u_read_return
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .rr_access     (rr_access),
      .rr_packet     (rr_packet),
      .req_issued    (req_issued),
      .cur_size      (cur_size),
      .rid           (rid),
      .rlast         (rlast),
      .s_axi_r       (s_axi_r),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .r_take        (r_take)
     );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
  #(
   parameter int reset_cycles = 8
  )
  (
   output logic clk,
   output logic resetn
  );

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      resetn = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      resetn <= 1'b1;   // released on an edge, like any other input
   end

endmodule

// File: bench/tb_esaxi.sv
`timescale 1ns/1ps

module tb_esaxi;

   import esaxi_pkg::*;

   localparam int          tw          = 6;              // expiry after ~64 cycles
   localparam logic [31:0] return_addr = 32'h0000_8a40;
   localparam logic [31:0] seed        = 32'd68;
   localparam int          wait_limit  = 200;            // cycles per handshake wait
   // twelve bus transactions of under 100 cycles each plus one 64-cycle expiry
   localparam int          cycle_limit = 3000;

   logic          clk;
   logic          resetn;
   axi_aw_t       s_axi_aw;
   logic          s_axi_awvalid;
   logic          s_axi_awready;
   axi_w_t        s_axi_w;
   logic          s_axi_wvalid;
   logic          s_axi_wready;
   axi_b_t        s_axi_b;
   logic          s_axi_bvalid;
   logic          s_axi_bready;
   axi_ar_t       s_axi_ar;
   logic          s_axi_arvalid;
   logic          s_axi_arready;
   axi_r_t        s_axi_r;
   logic          s_axi_rvalid;
   logic          s_axi_rready;
   logic          wr_access;
   emesh_packet_t wr_packet;
   logic          wr_wait;
   logic          rd_access;
   emesh_packet_t rd_packet;
   logic          rd_wait;
   logic          rr_access;
   emesh_packet_t rr_packet;

   int            checks;
   int            errors;
   int            cycles;
   logic [31:0]   rnd;                 // stimulus stream
   logic [31:0]   resp_rnd;            // responder stream
   logic          responder_on;
   logic [31:0]   wbeat_data [4];
   logic [3:0]    wbeat_strb [4];
   emesh_packet_t wr_seen [$];         // write packets from the monitor
   axi_b_t        b_seen [$];
   emesh_packet_t rd_seen [$];         // read requests taken by the mesh
   logic [31:0]   sent_data [$];       // data the responder returned

   tb_clock u_clock (.clk(clk), .resetn(resetn));

   esaxi_top #(.tw(tw), .return_addr(return_addr)) u_dut
     (
      .s_axi_aclk    (clk),
      .s_axi_aresetn (resetn),
      .s_axi_aw      (s_axi_aw),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_w       (s_axi_w),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_b       (s_axi_b),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_ar      (s_axi_ar),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_r       (s_axi_r),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .wr_access     (wr_access),
      .wr_packet     (wr_packet),
      .wr_wait       (wr_wait),
      .rd_access     (rd_access),
      .rd_packet     (rd_packet),
      .rd_wait       (rd_wait),
      .rr_access     (rr_access),
      .rr_packet     (rr_packet)
     );

   // ################################################
   // helpers
   // ################################################

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rnd = xorshift(rnd);
      return rnd;
   endfunction

   // index of the first enabled byte lane or lane 3 when none
   function automatic int lowest_strobe(input logic [3:0] strb);
      int i;
      for (i = 0; i < 4; i++)
         if (strb[i])
            return i;
      return 3;
   endfunction

   // narrow read data copied onto every lane
   function automatic logic [31:0] replicate(input logic [31:0] d, input logic [2:0] size);
      case (size)
         3'd0    : return {4{d[7:0]}};
         3'd1    : return {2{d[15:0]}};
         default : return d;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before)
         $display("%s: pass", name);
      else
         $display("%s: %0d errors", name, errors - errors_before);
   endtask

   // ################################################
   // monitor and mesh responder
   // ################################################

   always @(posedge clk)
   begin
      if (resetn && wr_access)
         wr_seen.push_back(wr_packet);
      if (resetn && s_axi_bvalid && s_axi_bready)
         b_seen.push_back(s_axi_b);
   end

   always @(posedge clk)
   begin
      rr_access <= 1'b0;   // single-cycle response
      if (resetn && rd_access && !rd_wait)
      begin
         rd_seen.push_back(rd_packet);
         if (responder_on)
         begin
            resp_rnd = xorshift(resp_rnd);
            sent_data.push_back(resp_rnd);
            rr_access         <= 1'b1;
            rr_packet         <= '0;
            rr_packet.dstaddr <= rd_packet.srcaddr;   // back to the requester
            rr_packet.data    <= resp_rnd;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("run stopped, cycle limit of %0d reached", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   // ################################################
   // bus drivers
   // ################################################

   task automatic axi_write(input logic [11:0] awid, input logic [31:0] awaddr,
                            input logic [2:0] awsize, input int beats, input bit throttle);
      int          n;
      int          k;
      logic [31:0] r;
      @(posedge clk);
      s_axi_aw      <= '{id: awid, addr: awaddr, size: awsize, burst: burst_incr};
      s_axi_awvalid <= 1'b1;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!s_axi_awready && n < wait_limit);
      s_axi_awvalid <= 1'b0;
      if (!s_axi_awready)
         report_failure("write address was never accepted");
      for (k = 0; k < beats; k++)
      begin
         s_axi_w      <= '{data: wbeat_data[k], strb: wbeat_strb[k], last: (k == beats - 1)};
         s_axi_wvalid <= 1'b1;
         n = 0;
         do
         begin
            if (throttle)
            begin
               r = next_rand();
               wr_wait <= r[9];   // mesh busy about half the time
            end
            @(posedge clk);
            n++;
         end
         while (!s_axi_wready && n < wait_limit);
         if (!s_axi_wready)
            report_failure("write data beat was never accepted");
      end
      s_axi_wvalid <= 1'b0;
      wr_wait      <= 1'b0;
   endtask

   task automatic expect_writes(input logic [11:0] awid, input logic [31:0] awaddr,
                                input logic [2:0] awsize, input int beats);
      int            n;
      int            k;
      int            lo;
      logic [31:0]   exp_addr;
      emesh_packet_t pkt;
      axi_b_t        b;
      n = 0;
      while ((wr_seen.size() < beats || b_seen.size() < 1) && n < wait_limit)
      begin
         @(posedge clk);
         n++;
      end
      repeat (4) @(posedge clk);   // room for strays
      check_eq("write packet count", wr_seen.size(), beats);
      check_eq("b response count", b_seen.size(), 1);
      for (k = 0; k < beats && wr_seen.size() > 0; k++)
      begin
         pkt      = wr_seen.pop_front();
         lo       = lowest_strobe(wbeat_strb[k]);
         exp_addr = {awaddr[31:2], 2'b00} + 32'(4 * k) + 32'(lo);
         check_eq("wr_packet.write", pkt.write, 1'b1);
         check_eq("wr_packet.datamode", pkt.datamode, awsize[1:0]);
         check_eq("wr_packet.ctrlmode", pkt.ctrlmode, 5'd0);
         check_eq("wr_packet.srcaddr", pkt.srcaddr, 32'd0);
         check_eq("wr_packet.dstaddr", pkt.dstaddr, exp_addr);
         check_eq("wr_packet.data", pkt.data, wbeat_data[k] >> (8 * lo));
      end
      if (b_seen.size() > 0)
      begin
         b = b_seen.pop_front();
         check_eq("bid", b.id, awid);
         check_eq("bresp", b.resp, resp_okay);
      end
      wr_seen.delete();
      b_seen.delete();
   endtask

   task automatic axi_read(input logic [11:0] arid, input logic [31:0] araddr,
                           input logic [7:0] arlen, input logic [2:0] arsize,
                           input int stall, input bit expect_timeout);
      int            n;
      int            k;
      logic [31:0]   exp_data;
      logic [31:0]   exp_addr;
      emesh_packet_t req;
      @(posedge clk);
      s_axi_ar      <= '{id: arid, addr: araddr, len: arlen, size: arsize, burst: burst_incr};
      s_axi_arvalid <= 1'b1;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!s_axi_arready && n < wait_limit);
      s_axi_arvalid <= 1'b0;
      if (!s_axi_arready)
         report_failure("read address was never accepted");
      for (k = 0; k <= arlen; k++)
      begin
         if (stall > 0)
            rd_wait <= 1'b1;   // request must hold through this
         n = 0;
         do
         begin
            @(posedge clk);
            n++;
            if (n == stall)
               rd_wait <= 1'b0;
         end
         while (!s_axi_rvalid && n < wait_limit);
         if (!s_axi_rvalid)
            report_failure("read data beat never returned");
         else
         begin
            exp_data = timeout_data;
            if (!expect_timeout && sent_data.size() == 0)
               report_failure("read beat returned with no response packet sent");
            else if (!expect_timeout)
               exp_data = sent_data.pop_front();
            check_eq("rdata", s_axi_r.data, replicate(exp_data, arsize));
            check_eq("rresp", s_axi_r.resp, expect_timeout ? resp_slverr : resp_okay);
            check_eq("rid", s_axi_r.id, arid);
            check_eq("rlast", s_axi_r.last, k == arlen);
         end
         if (rd_seen.size() == 0)
            report_failure("no read request packet seen for this beat");
         else
         begin
            req      = rd_seen.pop_front();
            exp_addr = (k == 0) ? araddr : {araddr[31:2], 2'b00} + 32'(4 * k);
            check_eq("rd_packet.write", req.write, 1'b0);
            check_eq("rd_packet.dstaddr", req.dstaddr, exp_addr);
            check_eq("rd_packet.srcaddr", req.srcaddr, return_addr);
         end
      end
      repeat (3) @(posedge clk);
      check_eq("extra read requests", rd_seen.size(), 0);
   endtask

   // ################################################
   // tests
   // ################################################

   task automatic single_write();
      int          e0;
      logic [31:0] r;
      logic [31:0] addr;
      e0   = errors;
      r    = next_rand();
      addr = next_rand();
      wbeat_data[0] = next_rand();
      wbeat_strb[0] = 4'hf;
      axi_write(r[11:0], addr, 3'd2, 1, 1'b0);
      expect_writes(r[11:0], addr, 3'd2, 1);
      report_test("single full-strobe write", e0);
   endtask

   task automatic strobe_writes();
      int          e0;
      int          s;
      logic [31:0] r;
      logic [31:0] addr;
      e0 = errors;
      for (s = 0; s < 4; s++)
      begin
         r    = next_rand();
         addr = next_rand();
         wbeat_data[0] = next_rand();
         wbeat_strb[0] = 4'b0001 << s;   // one lane only
         axi_write(r[11:0], addr, 3'd0, 1, 1'b0);
         expect_writes(r[11:0], addr, 3'd0, 1);
      end
      report_test("partial-strobe writes", e0);
   endtask

   task automatic burst_write();
      int          e0;
      int          k;
      logic [31:0] r;
      logic [31:0] addr;
      e0   = errors;
      r    = next_rand();
      addr = next_rand();
      for (k = 0; k < 4; k++)
      begin
         wbeat_data[k] = next_rand();
         wbeat_strb[k] = 4'hf;
      end
      axi_write(r[11:0], addr, 3'd2, 4, 1'b1);
      expect_writes(r[11:0], addr, 3'd2, 4);
      report_test("four-beat burst write with wr_wait", e0);
   endtask

   task automatic single_reads();
      int          e0;
      int          s;
      logic [31:0] r;
      e0 = errors;
      for (s = 0; s < 3; s++)
      begin
         r = next_rand();
         axi_read(r[11:0], next_rand(), 8'd0, 3'(s), 0, 1'b0);
      end
      report_test("single reads of each size", e0);
   endtask

   task automatic burst_read();
      int          e0;
      logic [31:0] r;
      e0 = errors;
      r  = next_rand();
      axi_read(r[11:0], next_rand(), 8'd2, 3'd2, 4, 1'b0);
      report_test("three-beat burst read with rd_wait", e0);
   endtask

   task automatic timeout_read();
      int          e0;
      logic [31:0] r;
      e0 = errors;
      responder_on <= 1'b0;   // mesh stays silent
      r = next_rand();
      axi_read(r[11:0], next_rand(), 8'd0, 3'd2, 0, 1'b1);
      responder_on <= 1'b1;
      r = next_rand();
      axi_read(r[11:0], next_rand(), 8'd0, 3'd2, 0, 1'b0);
      report_test("read timeout then normal read", e0);
   endtask

   initial
   begin
      checks        = 0;
      errors        = 0;
      cycles        = 0;
      rnd           = seed;
      resp_rnd      = seed ^ 32'h5a5a_5a5a;
      responder_on  <= 1'b1;
      s_axi_aw      <= '0;
      s_axi_awvalid <= 1'b0;
      s_axi_w       <= '0;
      s_axi_wvalid  <= 1'b0;
      s_axi_bready  <= 1'b1;   // always ready for b and r
      s_axi_ar      <= '0;
      s_axi_arvalid <= 1'b0;
      s_axi_rready  <= 1'b1;
      wr_wait       <= 1'b0;
      rd_wait       <= 1'b0;
      rr_access     <= 1'b0;
      rr_packet     <= '0;
      @(posedge clk);
      while (!resetn)
         @(posedge clk);
      repeat (2) @(posedge clk);   // arready comes up after reset
      single_write();
      strobe_writes();
      burst_write();
      single_reads();
      burst_read();
      timeout_read();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: list.f
rtl/esaxi_pkg.sv
rtl/axi_write_slave.sv
rtl/write_packer.sv
rtl/axi_read_slave.sv
rtl/read_return.sv
rtl/esaxi_top.sv
bench/tb_clock.sv
bench/tb_esaxi.sv
